// File: regs_settings.svh
`ifndef REGS_SETTINGS_SVH
`define REGS_SETTINGS_SVH

// data path width
`define REGS_XLEN 32

// general register file geometry
`define REGS_GPR_AW 5
`define REGS_GPR_N 32

// control register file geometry
`define REGS_CSR_AW 3
`define REGS_CSR_N 8

// external interrupt lines are zero extended into the pending register
`define REGS_IRQ_W 16

// process id field held in the low bits of control register 1
`define REGS_PID_W 12

`endif

// File: regs_pkg.sv
`default_nettype none

`include "regs_settings.svh"

package regs_pkg;

  typedef logic [`REGS_XLEN-1:0]   word_t;
  typedef logic [`REGS_GPR_AW-1:0] gpr_addr_t;
  typedef logic [`REGS_CSR_AW-1:0] csr_addr_t;
  typedef logic [`REGS_IRQ_W-1:0]  irq_t;
  typedef logic [`REGS_PID_W-1:0]  pid_t;

  // command kinds issued by trap_ctrl
  typedef enum logic [1:0] {
    csr_nop,
    csr_write,
    csr_trap_enter,
    csr_trap_return
  } csr_op_e;

  // what the pipeline retires into the control registers
  typedef struct packed {
    logic      csr_wen;
    csr_addr_t csr_addr;
    word_t     csr_wdata;
    logic      exc;
    logic      tlb_exc;
    logic      irq_cause;
    logic      rfe;
    logic      rfi;
  } wb_event_t;

  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    word_t     data;
  } csr_cmd_t;

  // Wishbone classic request that the host holds until ack
  typedef struct packed {
    logic      cyc;
    logic      stb;
    logic      we;
    csr_addr_t addr;
    word_t     data;
  } wb_req_t;

endpackage

`default_nettype wire

// File: gpr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_settings.svh"

module gpr_file (
  input  wire                  clk,
  input  wire                  rst,
  input  regs_pkg::gpr_addr_t  raddr0,
  input  regs_pkg::gpr_addr_t  raddr1,
  output regs_pkg::word_t      rdata0,
  output regs_pkg::word_t      rdata1,
  input  logic                 wen0,
  input  logic                 wen1,
  input  regs_pkg::gpr_addr_t  waddr0,
  input  regs_pkg::gpr_addr_t  waddr1,
  input  regs_pkg::word_t      wdata0,
  input  regs_pkg::word_t      wdata1,
  input  logic                 stall,
  output regs_pkg::word_t      ret_val
);

  import regs_pkg::*;

  // return value register of the calling convention
  localparam gpr_addr_t RET_REG = gpr_addr_t'(3);

  word_t gpr_q [`REGS_GPR_N];
  logic  wen1_ok;

  // port 0 carries load and alu results, so it wins a collision
  assign wen1_ok = wen1 && !(wen0 && (waddr1 == waddr0));

  always_ff @(posedge clk) begin
    if (wen0) begin
      gpr_q[waddr0] <= wdata0;
    end
    if (wen1_ok) begin
      gpr_q[waddr1] <= wdata1;
    end
  end

  // registered reads return the old value on a same-cycle write
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata0 <= '0;
      rdata1 <= '0;
    end else if (!stall) begin
      rdata0 <= (raddr0 == '0) ? '0 : gpr_q[raddr0];
      rdata1 <= (raddr1 == '0) ? '0 : gpr_q[raddr1];
    end
  end

  assign ret_val = gpr_q[RET_REG];

  // the pipeline relies on operands holding across a stall
  a_rdata_hold: assert property (
    @(posedge clk) disable iff (rst)
    stall |=> ($stable(rdata0) && $stable(rdata1))
  ) else $error("gpr read data changed during stall");

endmodule

`default_nettype wire

// File: csr_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_settings.svh"

module csr_file (
  input  wire                  clk,
  input  wire                  rst,
  input  regs_pkg::csr_cmd_t   cmd,
  input  logic                 stall,
  input  regs_pkg::csr_addr_t  raddr,
  output regs_pkg::word_t      rdata,
  input  regs_pkg::csr_addr_t  dbg_addr,
  output regs_pkg::word_t      dbg_rdata,
  input  regs_pkg::word_t      epc,
  input  regs_pkg::word_t      efg,
  input  regs_pkg::word_t      tlb_addr,
  input  logic                 tlb_exc,
  input  logic                 irq_cause,
  input  logic                 rfi,
  input  regs_pkg::irq_t       irq,
  output logic                 kmode,
  output regs_pkg::pid_t       pid,
  output regs_pkg::word_t      cdv,
  output regs_pkg::word_t      irq_state
);

  import regs_pkg::*;

  localparam csr_addr_t CSR_STATE = csr_addr_t'(0);
  localparam csr_addr_t CSR_PID   = csr_addr_t'(1);
  localparam csr_addr_t CSR_PEND  = csr_addr_t'(2);
  localparam csr_addr_t CSR_MASK  = csr_addr_t'(3);
  localparam csr_addr_t CSR_EPC   = csr_addr_t'(4);
  localparam csr_addr_t CSR_EFG   = csr_addr_t'(5);
  localparam csr_addr_t CSR_CDV   = csr_addr_t'(6);
  localparam csr_addr_t CSR_TLB   = csr_addr_t'(7);

  // global interrupt enable in the mask register
  localparam int GIE = `REGS_XLEN - 1;

  word_t csr_q [`REGS_CSR_N];
  word_t pend_d;
  logic  trap_op;

  assign trap_op = (cmd.op == csr_trap_enter) || (cmd.op == csr_trap_return);

  // irq lines are never lost, even under a software write to pending
  assign pend_d = ((cmd.op == csr_write && cmd.addr == CSR_PEND) ? cmd.data : csr_q[CSR_PEND])
                  | word_t'(irq);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `REGS_CSR_N; i++) begin
        csr_q[i] <= '0;
      end
      // come out of reset in kernel mode
      csr_q[CSR_STATE] <= word_t'(1);
    end else begin
      case (cmd.op)
        csr_write: csr_q[cmd.addr] <= cmd.data;
        csr_trap_enter: begin
          csr_q[CSR_EPC]   <= epc;
          csr_q[CSR_EFG]   <= efg;
          csr_q[CSR_STATE] <= csr_q[CSR_STATE] + word_t'(1);
          if (tlb_exc) begin
            csr_q[CSR_TLB] <= tlb_addr;
          end
          if (irq_cause) begin
            csr_q[CSR_MASK][GIE] <= 1'b0;
          end
        end
        csr_trap_return: begin
          csr_q[CSR_STATE] <= csr_q[CSR_STATE] - word_t'(1);
          if (rfi) begin
            csr_q[CSR_MASK][GIE] <= 1'b1;
          end
        end
        default: ;
      endcase
      // overrides the plain write above for the pending register
      csr_q[CSR_PEND] <= pend_d;
    end
  end

  // pipeline read port is frozen by stall and by trap commands
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else if (!stall && !trap_op) begin
      rdata <= (raddr == '0) ? '0 : csr_q[raddr];
    end
  end

  // debug sees every register as stored
  always_ff @(posedge clk) begin
    dbg_rdata <= csr_q[dbg_addr];
  end

  assign kmode     = (csr_q[CSR_STATE] != '0);
  assign pid       = csr_q[CSR_PID][`REGS_PID_W-1:0];
  assign cdv       = csr_q[CSR_CDV];
  assign irq_state = csr_q[CSR_MASK][GIE] ? (csr_q[CSR_PEND] & csr_q[CSR_MASK]) : '0;

  // trap_ctrl must never return from user mode
  a_state_no_underflow: assert property (
    @(posedge clk) disable iff (rst)
    (cmd.op == csr_trap_return) |-> (csr_q[CSR_STATE] != '0)
  ) else $error("trap return with processor state already zero");

endmodule

`default_nettype wire

// File: trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_settings.svh"

module trap_ctrl (
  input  wire                  clk,
  input  wire                  rst,
  input  regs_pkg::wb_event_t  evt,
  input  logic                 stall,
  input  regs_pkg::wb_req_t    dbg_req,
  output logic                 dbg_ack,
  output regs_pkg::csr_cmd_t   cmd,
  output logic                 tlb_exc,
  output logic                 irq_cause,
  output logic                 rfi
);

  import regs_pkg::*;

  typedef enum logic {
    st_idle,
    st_ack
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   trap_go;
  logic   ret_go;
  logic   pipe_busy;
  logic   dbg_pend;
  logic   dbg_accept;

  // traps wait for the stall to clear but plain csr writes do not
  assign trap_go   = evt.exc && !stall;
  assign ret_go    = evt.rfe && !stall;
  assign pipe_busy = trap_go || ret_go || evt.csr_wen;

  // a request being acked is still held by the host and is ignored then
  assign dbg_pend   = (state_q == st_idle) && dbg_req.cyc && dbg_req.stb;
  assign dbg_accept = dbg_pend && !pipe_busy;

  always_comb begin
    cmd.op   = csr_nop;
    cmd.addr = evt.csr_addr;
    cmd.data = evt.csr_wdata;
    if (trap_go) begin
      cmd.op = csr_trap_enter;
    end else if (ret_go) begin
      cmd.op = csr_trap_return;
    end else if (evt.csr_wen) begin
      cmd.op = csr_write;
    end else if (dbg_accept) begin
      // a debug read needs no command since its data is sampled this cycle
      cmd.op   = dbg_req.we ? csr_write : csr_nop;
      cmd.addr = dbg_req.addr;
      cmd.data = dbg_req.data;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle: if (dbg_accept) state_d = st_ack;
      st_ack:  state_d = st_idle;
      default: state_d = st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign dbg_ack = (state_q == st_ack);

  // cause qualifiers only matter alongside a trap command
  assign tlb_exc   = evt.tlb_exc;
  assign irq_cause = evt.irq_cause;
  assign rfi       = evt.rfi;

  a_ack_single: assert property (
    @(posedge clk) disable iff (rst)
    dbg_ack |=> !dbg_ack
  ) else $error("dbg_ack high on two consecutive cycles");

  a_ack_in_cycle: assert property (
    @(posedge clk) disable iff (rst)
    dbg_ack |-> (dbg_req.cyc && dbg_req.stb)
  ) else $error("dbg_ack without an active request");

endmodule

`default_nettype wire

// File: regs_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_settings.svh"

module regs_top (
  input  wire                  clk,
  input  wire                  rst,
  input  regs_pkg::gpr_addr_t  raddr0,
  input  regs_pkg::gpr_addr_t  raddr1,
  output regs_pkg::word_t      rdata0,
  output regs_pkg::word_t      rdata1,
  input  logic                 wen0,
  input  logic                 wen1,
  input  regs_pkg::gpr_addr_t  waddr0,
  input  regs_pkg::gpr_addr_t  waddr1,
  input  regs_pkg::word_t      wdata0,
  input  regs_pkg::word_t      wdata1,
  input  logic                 stall,
  input  regs_pkg::wb_event_t  wb_evt,
  input  regs_pkg::word_t      epc,
  input  regs_pkg::word_t      efg,
  input  regs_pkg::word_t      tlb_addr,
  input  regs_pkg::irq_t       irq,
  input  regs_pkg::csr_addr_t  csr_raddr,
  output regs_pkg::word_t      csr_rdata,
  input  regs_pkg::wb_req_t    dbg_req,
  output logic                 dbg_ack,
  output regs_pkg::word_t      dbg_rdata,
  output logic                 kmode,
  output regs_pkg::pid_t       pid,
  output regs_pkg::word_t      cdv,
  output regs_pkg::word_t      irq_state,
  output regs_pkg::word_t      ret_val
);

  import regs_pkg::*;

  csr_cmd_t csr_cmd;
  logic     tlb_exc;
  logic     irq_cause;
  logic     rfi;

  gpr_file gpr_file_i (
    .clk, .rst,
    .raddr0, .raddr1, .rdata0, .rdata1,
    .wen0, .wen1, .waddr0, .waddr1, .wdata0, .wdata1,
    .stall, .ret_val
  );

  trap_ctrl trap_ctrl_i (
    .clk, .rst,
    .evt       (wb_evt),
    .stall, .dbg_req, .dbg_ack,
    .cmd       (csr_cmd),
    .tlb_exc, .irq_cause, .rfi
  );

  // debug address comes straight off the bus and stays until ack
  csr_file csr_file_i (
    .clk, .rst,
    .cmd       (csr_cmd),
    .stall,
    .raddr     (csr_raddr),
    .rdata     (csr_rdata),
    .dbg_addr  (dbg_req.addr),
    .dbg_rdata,
    .epc, .efg, .tlb_addr,
    .tlb_exc, .irq_cause, .rfi,
    .irq, .kmode, .pid, .cdv, .irq_state
  );

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
  parameter int HALF_NS = 5
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(HALF_NS) clk = ~clk;
  end

endmodule

`default_nettype wire

// File: regs_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "regs_settings.svh"

module regs_tb;

  import regs_pkg::*;

  localparam int RESET_CYCLES = 16;
  localparam int GPR_CYCLES   = 400;
  localparam int MIX_CYCLES   = 300;
  localparam int MIX_DBG      = 40;
  localparam int ACK_LIMIT    = 32;
  // directed csr tests plus a bounded wait for every debug access
  localparam int PLANNED = RESET_CYCLES + 2 * `REGS_GPR_N + GPR_CYCLES + 120
                         + (2 * `REGS_CSR_N + MIX_DBG) * (ACK_LIMIT + 2) + MIX_CYCLES;

  logic      clk;
  logic      rst;
  gpr_addr_t raddr0, raddr1, waddr0, waddr1;
  word_t     rdata0, rdata1, wdata0, wdata1, ret_val;
  logic      wen0, wen1, stall;
  wb_event_t wb_evt;
  word_t     epc, efg, tlb_addr, csr_rdata, dbg_rdata, cdv, irq_state;
  irq_t      irq;
  csr_addr_t csr_raddr;
  wb_req_t   dbg_req;
  logic      dbg_ack, kmode;
  pid_t      pid;
  int        mismatches = 0;
  int        failures = 0;

  tb_clock tb_clock_i (.clk);

  regs_top regs_top_i (
    .clk, .rst, .raddr0, .raddr1, .rdata0, .rdata1,
    .wen0, .wen1, .waddr0, .waddr1, .wdata0, .wdata1, .stall,
    .wb_evt, .epc, .efg, .tlb_addr, .irq, .csr_raddr, .csr_rdata,
    .dbg_req, .dbg_ack, .dbg_rdata, .kmode, .pid, .cdv, .irq_state, .ret_val
  );

  // shadow copies of the architectural state
  word_t     m_gpr [`REGS_GPR_N];
  word_t     m_csr [`REGS_CSR_N];
  word_t     m_rdata0, m_rdata1, m_csr_rdata, m_dbg_rdata;
  logic      m_ack, m_accept;
  csr_op_e   m_op;
  csr_addr_t m_addr;
  word_t     m_data;
  word_t     exp_irq_state;

  // one csr command per cycle with traps first and the debug host last
  always_comb begin
    m_op     = csr_nop;
    m_addr   = wb_evt.csr_addr;
    m_data   = wb_evt.csr_wdata;
    m_accept = 1'b0;
    if (wb_evt.exc && !stall) begin
      m_op = csr_trap_enter;
    end else if (wb_evt.rfe && !stall) begin
      m_op = csr_trap_return;
    end else if (wb_evt.csr_wen) begin
      m_op = csr_write;
    end else if (!m_ack && dbg_req.cyc && dbg_req.stb) begin
      m_accept = 1'b1;
      if (dbg_req.we) begin
        m_op   = csr_write;
        m_addr = dbg_req.addr;
        m_data = dbg_req.data;
      end
    end
  end

  always @(posedge clk) begin : model_update
    word_t pend;
    pend = ((m_op == csr_write && m_addr == 3'd2) ? m_data : m_csr[2]) | word_t'(irq);
    if (wen0) m_gpr[waddr0] <= wdata0;
    if (wen1 && !(wen0 && waddr1 == waddr0)) m_gpr[waddr1] <= wdata1;
    if (rst) begin
      for (int i = 0; i < `REGS_CSR_N; i++) m_csr[i] <= '0;
      m_csr[0]    <= 32'd1;
      m_rdata0    <= '0;
      m_rdata1    <= '0;
      m_csr_rdata <= '0;
      m_ack       <= 1'b0;
    end else begin
      if (!stall) begin
        m_rdata0 <= (raddr0 == '0) ? '0 : m_gpr[raddr0];
        m_rdata1 <= (raddr1 == '0) ? '0 : m_gpr[raddr1];
        if (m_op != csr_trap_enter && m_op != csr_trap_return)
          m_csr_rdata <= (csr_raddr == '0) ? '0 : m_csr[csr_raddr];
      end
      case (m_op)
        csr_write: m_csr[m_addr] <= m_data;
        csr_trap_enter: begin
          m_csr[4] <= epc;
          m_csr[5] <= efg;
          m_csr[0] <= m_csr[0] + 1;
          if (wb_evt.tlb_exc) m_csr[7] <= tlb_addr;
          if (wb_evt.irq_cause) m_csr[3][31] <= 1'b0;
        end
        csr_trap_return: begin
          m_csr[0] <= m_csr[0] - 1;
          if (wb_evt.rfi) m_csr[3][31] <= 1'b1;
        end
        default: ;
      endcase
      m_csr[2] <= pend;
      m_ack    <= m_accept;
      if (m_accept) m_dbg_rdata <= m_csr[dbg_req.addr];
    end
  end

  assign exp_irq_state = m_csr[3][31] ? (m_csr[2] & m_csr[3]) : '0;

  task automatic report_mismatch(string name, word_t expected, word_t actual);
    mismatches++;
    $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
  endtask

  a_rdata0: assert property (@(posedge clk) disable iff (rst) rdata0 === m_rdata0)
    else report_mismatch("rdata0", $sampled(m_rdata0), $sampled(rdata0));
  a_rdata1: assert property (@(posedge clk) disable iff (rst) rdata1 === m_rdata1)
    else report_mismatch("rdata1", $sampled(m_rdata1), $sampled(rdata1));
  a_ret_val: assert property (@(posedge clk) disable iff (rst) ret_val === m_gpr[3])
    else report_mismatch("ret_val", $sampled(m_gpr[3]), $sampled(ret_val));
  a_csr_rdata: assert property (@(posedge clk) disable iff (rst) csr_rdata === m_csr_rdata)
    else report_mismatch("csr_rdata", $sampled(m_csr_rdata), $sampled(csr_rdata));
  a_dbg_ack: assert property (@(posedge clk) disable iff (rst) dbg_ack === m_ack)
    else report_mismatch("dbg_ack", $sampled(m_ack), $sampled(dbg_ack));
  a_dbg_rdata: assert property (@(posedge clk) disable iff (rst)
    (m_ack && !dbg_req.we) |-> dbg_rdata === m_dbg_rdata)
    else report_mismatch("dbg_rdata", $sampled(m_dbg_rdata), $sampled(dbg_rdata));
  a_kmode: assert property (@(posedge clk) disable iff (rst) kmode === (m_csr[0] != '0))
    else report_mismatch("kmode", $sampled(m_csr[0] != '0), $sampled(kmode));
  a_pid: assert property (@(posedge clk) disable iff (rst)
    pid === m_csr[1][`REGS_PID_W-1:0])
    else report_mismatch("pid", $sampled(m_csr[1][`REGS_PID_W-1:0]), $sampled(pid));
  a_cdv: assert property (@(posedge clk) disable iff (rst) cdv === m_csr[6])
    else report_mismatch("cdv", $sampled(m_csr[6]), $sampled(cdv));
  a_irq_state: assert property (@(posedge clk) disable iff (rst) irq_state === exp_irq_state)
    else report_mismatch("irq_state", $sampled(exp_irq_state), $sampled(irq_state));

  function automatic wb_event_t csr_wr(csr_addr_t addr, word_t data);
    wb_event_t e;
    e = '0;
    e.csr_wen   = 1'b1;
    e.csr_addr  = addr;
    e.csr_wdata = data;
    return e;
  endfunction

  // event lives for one cycle as the pipeline retires it
  task automatic pipe_event(wb_event_t e);
    @(posedge clk);
    wb_evt <= e;
    @(posedge clk);
    wb_evt <= '0;
  endtask

  task automatic csr_sweep();
    for (int a = 0; a < `REGS_CSR_N; a++) begin
      @(posedge clk);
      csr_raddr <= csr_addr_t'(a);
    end
  endtask

  task automatic gpr_random(int cycles);
    gpr_addr_t a0;
    for (int i = 0; i < `REGS_GPR_N; i += 2) begin
      @(posedge clk);
      wen0   <= 1'b1;
      waddr0 <= gpr_addr_t'(i);
      wdata0 <= $urandom;
      wen1   <= 1'b1;
      waddr1 <= gpr_addr_t'(i + 1);
      wdata1 <= $urandom;
    end
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      a0 = gpr_addr_t'($urandom);
      wen0   <= ($urandom % 4) != 0;
      wen1   <= ($urandom % 3) != 0;
      waddr0 <= a0;
      // every fourth cycle both ports hit one register
      waddr1 <= (n % 4 == 0) ? a0 : gpr_addr_t'($urandom);
      wdata0 <= $urandom;
      wdata1 <= $urandom;
      raddr0 <= (n % 5 == 0) ? a0 : gpr_addr_t'($urandom);
      raddr1 <= gpr_addr_t'($urandom);
      stall  <= ($urandom % 8) == 0;
    end
    @(posedge clk);
    wen0  <= 1'b0;
    wen1  <= 1'b0;
    stall <= 1'b0;
  endtask

  task automatic trap_and_irq_tests();
    pipe_event(csr_wr(3'd3, 32'h8000_00ff));
    epc      <= $urandom;
    efg      <= $urandom;
    tlb_addr <= $urandom;
    pipe_event('{exc: 1'b1, tlb_exc: 1'b1, irq_cause: 1'b1, default: '0});
    csr_sweep();
    pipe_event('{rfe: 1'b1, rfi: 1'b1, default: '0});
    csr_sweep();
    // back to user mode and into kernel mode again
    pipe_event(csr_wr(3'd0, 32'd1));
    pipe_event('{rfe: 1'b1, default: '0});
    pipe_event(csr_wr(3'd0, 32'd1));
    for (int i = 0; i < 6; i++) begin
      @(posedge clk);
      irq <= irq_t'($urandom);
      @(posedge clk);
      irq <= '0;
    end
    // irq bits arriving with a software write to pending
    @(posedge clk);
    wb_evt <= csr_wr(3'd2, $urandom);
    irq    <= irq_t'($urandom);
    @(posedge clk);
    wb_evt <= '0;
    irq    <= '0;
    pipe_event(csr_wr(3'd3, 32'h0000_ffff));
    pipe_event(csr_wr(3'd3, 32'h8000_ffff));
    csr_sweep();
  endtask

  task automatic dbg_access(logic we, csr_addr_t addr, word_t data);
    wb_req_t r;
    int      waited;
    r      = '{cyc: 1'b1, stb: 1'b1, we: we, addr: addr, data: data};
    waited = 0;
    @(posedge clk);
    dbg_req <= r;
    do begin
      @(posedge clk);
      waited++;
    end while (!dbg_ack && waited < ACK_LIMIT);
    if (!dbg_ack) begin
      failures++;
      $display("debug access to csr %0d got no acknowledge in %0d cycles", addr, ACK_LIMIT);
    end
    dbg_req <= '0;
  endtask

  task automatic dbg_random(int count, logic sweep);
    csr_addr_t a;
    logic      we;
    for (int n = 0; n < count; n++) begin
      a  = sweep ? csr_addr_t'(n) : csr_addr_t'($urandom);
      we = sweep ? (n < `REGS_CSR_N) : 1'($urandom);
      // the state register is kept at two or more
      dbg_access(we, a, (a == '0) ? 32'd2 + ($urandom % 4) : $urandom);
    end
  endtask

  task automatic pipe_random(int cycles);
    wb_event_t e;
    for (int n = 0; n < cycles; n++) begin
      @(posedge clk);
      e = '0;
      case ($urandom % 8)
        0: e = '{exc: 1'b1, tlb_exc: 1'($urandom), irq_cause: 1'($urandom), default: '0};
        1: if (m_csr[0] >= 2) e = '{rfe: 1'b1, rfi: 1'($urandom), default: '0};
        2, 3: e = csr_wr(csr_addr_t'($urandom), $urandom);
        default: ;
      endcase
      if (e.csr_wen && e.csr_addr == '0) e.csr_wdata = 32'd2 + ($urandom % 4);
      wb_evt    <= e;
      stall     <= ($urandom % 6) == 0;
      irq       <= (($urandom % 4) == 0) ? irq_t'($urandom) : '0;
      epc       <= $urandom;
      efg       <= $urandom;
      tlb_addr  <= $urandom;
      csr_raddr <= csr_addr_t'($urandom);
    end
    @(posedge clk);
    wb_evt <= '0;
    stall  <= 1'b0;
    irq    <= '0;
  endtask

  initial begin
    #(20 * PLANNED + 2000);
    $display("watchdog expired before the tests finished");
    $display("summary: %0d value mismatches, %0d other failures", mismatches, failures);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(32'hc842a423));
    rst <= 1'b1;
    {raddr0, raddr1, waddr0, waddr1} <= '0;
    {wdata0, wdata1, wen0, wen1, stall} <= '0;
    {epc, efg, tlb_addr, irq, csr_raddr} <= '0;
    wb_evt  <= '0;
    dbg_req <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    gpr_random(GPR_CYCLES);
    trap_and_irq_tests();
    dbg_random(2 * `REGS_CSR_N, 1'b1);
    fork
      pipe_random(MIX_CYCLES);
      dbg_random(MIX_DBG, 1'b0);
    join
    csr_sweep();
    repeat (4) @(posedge clk);
    $display("summary: %0d value mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
+incdir+.
regs_pkg.sv
gpr_file.sv
csr_file.sv
trap_ctrl.sv
regs_top.sv
tb_clock.sv
regs_tb.sv

// File: Bender.yml
package:
  name: regs_subsystem

export_include_dirs:
  - .

sources:
  - regs_pkg.sv
  - gpr_file.sv
  - csr_file.sv
  - trap_ctrl.sv
  - regs_top.sv
  - target: test
    files:
      - tb_clock.sv
      - regs_tb.sv
